//--- digit_scan.sv
`timescale 1ns/1ps

module digit_scan #(
	parameter int DIGIT_CYCLES = 50_000
) (
	input  logic           clk,
	input  logic           rst_n,
	input  race_pkg::bcd_t score,
	output logic [3:0]     sel,
	output logic [7:0]     sco_data
);

	localparam int CNT_BITS = $clog2(DIGIT_CYCLES + 1);

	logic [CNT_BITS-1:0] cnt;
	logic [1:0]          idx;	// 0 is the ones digit
	logic [3:0]          digit;
	logic [7:0]          seg;

	assign digit = score[{idx, 2'b00} +: 4];
	assign seg   = (digit <= 4'd9) ? race_pkg::SEG_CODE[digit] : 8'hFF;	// blank

	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n) begin
			cnt      <= '0;
			idx      <= 2'd0;
			sel      <= 4'b1111;
			sco_data <= 8'hFF;
		end else if (cnt == CNT_BITS'(DIGIT_CYCLES - 1)) begin
			cnt      <= '0;
			idx      <= idx + 1'b1;
			sel      <= ~(4'b0001 << idx);	// active low select
			sco_data <= seg;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  left_press,
	input  logic                  right_press,
	input  logic                  ena_press,
	input  logic                  crash,
	output race_pkg::game_state_t state,
	output race_pkg::lane_t       lane,
	output logic                  start_run
);

	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n) begin
			state     <= race_pkg::ST_IDLE;
			lane      <= race_pkg::LANE_START;
			start_run <= 1'b0;
		end else begin
			start_run <= 1'b0;
			case (state)
				race_pkg::ST_IDLE: begin
					if (ena_press) begin
						state     <= race_pkg::ST_RUN;
						lane      <= race_pkg::LANE_START;
						start_run <= 1'b1;
					end
				end
				race_pkg::ST_RUN: begin
					// offset still stale on the first run cycle
					if (crash && !start_run)
						state <= race_pkg::ST_CRASHED;
					else if (ena_press)
						state <= race_pkg::ST_IDLE;
					else if (right_press && lane < race_pkg::LANE_MAX)
						lane <= lane + 1'b1;
					else if (left_press && lane > race_pkg::LANE_MIN)
						lane <= lane - 1'b1;
				end
				race_pkg::ST_CRASHED: begin
					if (ena_press)
						state <= race_pkg::ST_IDLE;
				end
				default: state <= race_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

//--- key_filter.sv
`timescale 1ns/1ps

module key_filter #(
	parameter int PRESS_CYCLES = 1_000_000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic key,
	output logic press
);

	localparam int CNT_BITS = $clog2(PRESS_CYCLES + 1);

	logic [CNT_BITS-1:0] cnt;
	logic                at_top;
	logic                at_top_q;

	assign at_top = (cnt == CNT_BITS'(PRESS_CYCLES));

	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n) begin
			cnt      <= '0;
			at_top_q <= 1'b0;
			press    <= 1'b0;
		end else begin
			if (!key)
				cnt <= '0;
			else if (!at_top)
				cnt <= cnt + 1'b1;	// saturates at the threshold
			at_top_q <= at_top;
			press    <= at_top && !at_top_q;	// one pulse per hold
		end
	end

endmodule

//--- matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan #(
	parameter int ROW_HOLD_CYCLES = 25_000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  race_pkg::row_t                row_bits,
	output logic [race_pkg::ROW_BITS-1:0] row_addr,
	output logic                          c_data,
	output logic                          c_clk,
	output logic                          c_st,
	output logic [3:0]                    c_addr
);

	localparam int HOLD_BITS = $clog2(ROW_HOLD_CYCLES + 1);

	localparam logic [1:0] PH_SHIFT = 2'd0;
	localparam logic [1:0] PH_CLOCK = 2'd1;
	localparam logic [1:0] PH_HOLD  = 2'd2;

	logic [1:0]           phase;
	logic [3:0]           bit_cnt;
	logic [HOLD_BITS-1:0] hold_cnt;
	race_pkg::row_t       shreg;

	assign row_addr = c_addr;	// row being shifted is the one latched next

	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n) begin
			phase    <= PH_SHIFT;
			bit_cnt  <= 4'd0;
			hold_cnt <= '0;
			shreg    <= '1;
			c_data   <= 1'b0;
			c_clk    <= 1'b0;
			c_st     <= 1'b0;
			c_addr   <= 4'd0;
		end else begin
			case (phase)
				PH_SHIFT: begin
					c_clk <= 1'b0;
					if (bit_cnt == 4'd0) begin
						// driver lights a pixel on a low bit
						c_data <= ~row_bits[15];
						shreg  <= {~row_bits[14:0], 1'b1};
					end else begin
						c_data <= shreg[15];
						shreg  <= {shreg[14:0], 1'b1};
					end
					phase <= PH_CLOCK;
				end
				PH_CLOCK: begin
					c_clk   <= 1'b1;
					bit_cnt <= bit_cnt + 1'b1;	// wraps to 0 after bit 15
					phase   <= (bit_cnt == 4'd15) ? PH_HOLD : PH_SHIFT;
				end
				PH_HOLD: begin
					c_clk <= 1'b0;
					if (hold_cnt == HOLD_BITS'(ROW_HOLD_CYCLES)) begin
						hold_cnt <= '0;
						c_st     <= 1'b0;
						c_addr   <= c_addr + 1'b1;
						phase    <= PH_SHIFT;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
						c_st     <= 1'b1;
					end
				end
				default: phase <= PH_SHIFT;
			endcase
		end
	end

endmodule

//--- race.f
race_pkg.sv
key_filter.sv
game_fsm.sv
step_timer.sv
road_frame.sv
score_counter.sv
digit_scan.sv
matrix_scan.sv
race_top.sv
race_tb.sv

//--- race_pkg.sv
package race_pkg;

	localparam int MATRIX_SIZE = 16;
	localparam int ROW_BITS    = 4;
	localparam int ROUTE_ROWS  = 32;
	localparam int OFFSET_BITS = 5;

	typedef logic [MATRIX_SIZE-1:0] row_t;	// bit 15 is the leftmost column
	typedef logic [3:0]             lane_t;
	typedef logic [15:0]            bcd_t;	// ones digit in 3:0

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_RUN     = 2'd1,
		ST_CRASHED = 2'd2
	} game_state_t;

	localparam lane_t LANE_MIN   = 4'd1;
	localparam lane_t LANE_MAX   = 4'd12;
	localparam lane_t LANE_START = 4'd6;

	// car sprite, top row first, bit 0 sits on column lane
	localparam logic [2:0] CAR_ROWS [4] = '{3'b010, 3'b101, 3'b101, 3'b010};

	localparam int CRASH_ROW = 3;	// bottom row of the car

	// looping track, walls on both edges
	// first eight rows are open road for a safe start
	localparam row_t ROUTE [ROUTE_ROWS] = '{
		16'h8001, 16'h8001, 16'h8001, 16'h8001,
		16'h8001, 16'h8001, 16'h8001, 16'h8001,
		16'h8811, 16'h8001, 16'h8081, 16'h8001,
		16'hF801, 16'h8001, 16'h8201, 16'h8011,
		16'h8001, 16'hE01F, 16'h8001, 16'h8101,
		16'h8041, 16'h8001, 16'hFC01, 16'h8001,
		16'h8007, 16'h8001, 16'h8151, 16'h8001,
		16'h8C01, 16'h8301, 16'h8001, 16'hA045
	};

	// active low segments, digits 0 to 9
	localparam logic [7:0] SEG_CODE [10] = '{
		8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
		8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
		8'b0000_0001, 8'b0000_1001
	};

endpackage

//--- race_tb.sv
`timescale 1ns/1ps

module race_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int STEP_CYCLES  = 300;
	localparam int DIGIT_CYCLES = 5;
	localparam int ROW_CYCLES   = 2 * 16 + 8 + 2;
	// key presses, frame sweeps and a crash run across the whole route
	localparam int PLAN_CYCLES  = 60 * 12 + 14 * 17 * ROW_CYCLES + 44 * STEP_CYCLES;

	logic       clk, rst_n, on_off, pause, left, right, ena;
	logic [7:0] sco_data, lled;
	logic [3:0] sel, c_addr;
	logic       c_oe, c_clk, c_st, c_data;

	int          seed = 88;
	int          exp_state, exp_lane, exp_steps;
	int          rows_seen, rows_checked, digits_checked, bit_cnt;
	logic [15:0] cap_bits, cap_row;
	logic [3:0]  cap_addr;
	logic        rows_on, digits_on;

	race_top #(.PRESS_CYCLES(4), .STEP_CYCLES(STEP_CYCLES), .ROW_HOLD_CYCLES(8),
		.DIGIT_CYCLES(DIGIT_CYCLES)) UUT (
		.clk(clk), .rst_n(rst_n), .on_off(on_off), .pause(pause), .left(left),
		.right(right), .ena(ena), .sco_data(sco_data), .sel(sel), .lled(lled),
		.c_oe(c_oe), .c_clk(c_clk), .c_st(c_st), .c_data(c_data), .c_addr(c_addr)
	);

	function automatic logic [15:0] ref_row(int offset, int lane, bit show_car, int r);
		logic [15:0] row;
		row = race_pkg::ROUTE[(offset + r) % race_pkg::ROUTE_ROWS];
		if (show_car && r < 4)
			row = row | (16'(race_pkg::CAR_ROWS[r]) << lane);
		return row;
	endfunction

	function automatic bit crash_at(int offset, int lane);
		logic [15:0] under;
		under = race_pkg::ROUTE[(offset + race_pkg::CRASH_ROW) % race_pkg::ROUTE_ROWS] >> lane;
		return |under[2:0];
	endfunction

	function automatic logic [15:0] to_bcd(int n);
		return {4'(n / 1000 % 10), 4'(n / 100 % 10), 4'(n / 10 % 10), 4'(n % 10)};
	endfunction

	task automatic fail_run(string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string name, int expected, int actual);
		fail_run($sformatf("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h",
			$time, name, expected, actual));
	endtask

	// 0 left, 1 right, 2 ena
	task automatic press_key(int which, int hold);
		left  = (which == 0);
		right = (which == 1);
		ena   = (which == 2);
		repeat (hold) @(posedge clk);
		#10 {left, right, ena} = 3'b000;
		repeat (3) @(posedge clk);
		#10;
		if (which == 0 && exp_state == race_pkg::ST_RUN && exp_lane > race_pkg::LANE_MIN)
			exp_lane--;
		else if (which == 1 && exp_state == race_pkg::ST_RUN && exp_lane < race_pkg::LANE_MAX)
			exp_lane++;
		else if (which == 2 && exp_state == race_pkg::ST_IDLE) begin
			exp_state = race_pkg::ST_RUN;
			exp_lane  = race_pkg::LANE_START;
			exp_steps = 0;
		end else if (which == 2)
			exp_state = race_pkg::ST_IDLE;
		assert (lled == 8'(exp_state)) else report_mismatch("lled", exp_state, lled);
	endtask

	task automatic run_steps(int k);
		pause = 0;
		repeat (k * STEP_CYCLES) @(posedge clk);
		#10 pause = 1;
		exp_steps += k;
		repeat (3) @(posedge clk);
		#10;
		assert (lled == 8'(exp_state)) else report_mismatch("lled", exp_state, lled);
	endtask

	task automatic check_frame();
		int n0;
		n0 = rows_seen;
		wait (rows_seen != n0);	// drop the row already in flight
		@(negedge clk);
		#1 rows_on = 1;
		n0 = rows_checked;
		wait (rows_checked >= n0 + race_pkg::MATRIX_SIZE);
		rows_on = 0;
		@(posedge clk);
		#10;
	endtask

	task automatic check_digits();
		int n0;
		repeat (5 * DIGIT_CYCLES) @(posedge clk);
		#10 digits_on = 1;
		n0 = digits_checked;
		wait (digits_checked >= n0 + 8 * DIGIT_CYCLES);
		digits_on = 0;
		@(posedge clk);
		#10;
	endtask

	initial begin
		clk = 0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(2 * PLAN_CYCLES * CLK_PERIOD);
		fail_run("timeout: the tests did not finish in the expected time");
	end

	// shift register of the row driver, bits arrive inverted and MSB first
	initial begin
		bit_cnt = 0;
		forever begin
			@(posedge c_clk);
			cap_bits = {cap_bits[14:0], c_data};
			bit_cnt++;
			if (bit_cnt == 16) begin
				bit_cnt  = 0;
				cap_row  = ~cap_bits;
				cap_addr = c_addr;
				rows_seen++;
			end
		end
	end

	always @(negedge clk) begin
		int          rows_done;
		int          exp_addr;
		int          idx;
		logic [15:0] exp_row;
		logic [3:0]  digit;
		if (rows_seen != rows_done) begin
			rows_done = rows_seen;
			assert (cap_addr == 4'(exp_addr)) else report_mismatch("c_addr", exp_addr, cap_addr);
			exp_row = ref_row(exp_steps, exp_lane, exp_state != race_pkg::ST_IDLE, exp_addr);
			if (rows_on) begin
				assert (cap_row == exp_row) else
					report_mismatch($sformatf("matrix row %0d", exp_addr), exp_row, cap_row);
				rows_checked++;
			end
			exp_addr = (exp_addr + 1) % race_pkg::MATRIX_SIZE;
		end
		if (digits_on) begin
			idx = -1;
			for (int i = 0; i < 4; i++)
				if (sel == ~(4'b0001 << i))
					idx = i;
			if (idx < 0)
				fail_run($sformatf("sel %b does not select exactly one digit", sel));
			digit = 4'(to_bcd(exp_steps) >> (4 * idx));
			assert (sco_data == race_pkg::SEG_CODE[digit]) else
				report_mismatch($sformatf("sco_data digit %0d", idx),
					race_pkg::SEG_CODE[digit], sco_data);
			digits_checked++;
		end
	end

	initial begin
		int want, k, target, t, n;
		rst_n = 1;	// reset is active high
		{on_off, pause, left, right, ena} = 5'b01000;
		{rows_on, digits_on} = 2'b00;
		exp_state = race_pkg::ST_IDLE;
		exp_lane  = race_pkg::LANE_START;
		exp_steps = 0;
		repeat (10) @(posedge clk);
		#10;
		assert (lled == 8'd0) else report_mismatch("lled", 0, lled);
		assert (c_st == 1'b0) else report_mismatch("c_st", 0, c_st);
		assert (c_clk == 1'b0) else report_mismatch("c_clk", 0, c_clk);
		assert (sel == 4'b1111) else report_mismatch("sel", 4'b1111, sel);
		rst_n  = 0;
		on_off = 1;
		#1 assert (c_oe == 1'b0) else report_mismatch("c_oe", 0, c_oe);
		on_off = 0;
		#1 assert (c_oe == 1'b1) else report_mismatch("c_oe", 1, c_oe);
		@(posedge clk);
		#10;

		check_frame();
		press_key(2, 8);
		repeat (10) press_key($unsigned($random(seed)) % 2, 8);
		check_frame();
		repeat (13) press_key(0, 8);
		check_frame();
		repeat (13) press_key(1, 8);
		check_frame();
		press_key(0, 30);	// long hold, still one move
		check_frame();

		repeat (3) begin
			want = 1 + $unsigned($random(seed)) % 3;
			k = 0;
			while (k < want && !crash_at(exp_steps + k + 1, exp_lane))
				k++;
			run_steps(k);
			check_digits();
			check_frame();
		end

		press_key(2, 8);
		press_key(2, 8);
		check_digits();
		target = race_pkg::LANE_MIN + $unsigned($random(seed)) % 12;
		t = 1;
		while (t < race_pkg::ROUTE_ROWS && !crash_at(t, target))
			t++;
		if (t == race_pkg::ROUTE_ROWS)
			fail_run("no wall on the route for the chosen lane");
		while (exp_lane != target)
			press_key((exp_lane < target) ? 1 : 0, 8);
		pause = 0;
		n = 0;
		while (lled != 8'(race_pkg::ST_CRASHED) && n < (t + 2) * STEP_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (lled != 8'(race_pkg::ST_CRASHED))
			fail_run("the car drove onto a wall but the game did not crash");
		@(posedge clk);
		#10 pause = 1;
		exp_state = race_pkg::ST_CRASHED;
		exp_steps = t;
		check_digits();
		check_frame();
		pause = 0;
		repeat (2 * STEP_CYCLES) @(posedge clk);
		#10 pause = 1;
		check_digits();	// score frozen after the crash
		press_key(2, 8);
		press_key(2, 8);
		check_digits();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- race_top.sv
`timescale 1ns/1ps

module race_top #(
	parameter int PRESS_CYCLES    = 1_000_000,
	parameter int STEP_CYCLES     = 20_000_000,
	parameter int ROW_HOLD_CYCLES = 25_000,
	parameter int DIGIT_CYCLES    = 50_000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       on_off,
	input  logic       pause,
	input  logic       left,
	input  logic       right,
	input  logic       ena,
	output logic [7:0] sco_data,
	output logic [3:0] sel,
	output logic [7:0] lled,
	output logic       c_oe,
	output logic       c_clk,
	output logic       c_st,
	output logic       c_data,
	output logic [3:0] c_addr
);

	logic                          left_press;
	logic                          right_press;
	logic                          ena_press;
	logic                          crash;
	logic                          start_run;
	logic                          step;
	race_pkg::game_state_t         state;
	race_pkg::lane_t               lane;
	race_pkg::row_t                row_bits;
	race_pkg::bcd_t                score;
	logic [race_pkg::ROW_BITS-1:0] row_addr;

	key_filter #(.PRESS_CYCLES(PRESS_CYCLES)) u_key_left (
		.clk(clk), .rst_n(rst_n), .key(left), .press(left_press)
	);
	key_filter #(.PRESS_CYCLES(PRESS_CYCLES)) u_key_right (
		.clk(clk), .rst_n(rst_n), .key(right), .press(right_press)
	);
	key_filter #(.PRESS_CYCLES(PRESS_CYCLES)) u_key_ena (
		.clk(clk), .rst_n(rst_n), .key(ena), .press(ena_press)
	);

	game_fsm u_fsm (
		.clk(clk), .rst_n(rst_n),
		.left_press(left_press), .right_press(right_press), .ena_press(ena_press),
		.crash(crash), .state(state), .lane(lane), .start_run(start_run)
	);

	step_timer #(.STEP_CYCLES(STEP_CYCLES)) u_step (
		.clk(clk), .rst_n(rst_n), .state(state), .pause(pause),
		.start_run(start_run), .step(step)
	);

	road_frame u_road (
		.clk(clk), .rst_n(rst_n), .state(state), .lane(lane), .step(step),
		.start_run(start_run), .row_addr(row_addr), .row_bits(row_bits), .crash(crash)
	);

	score_counter u_score (
		.clk(clk), .rst_n(rst_n), .step(step), .start_run(start_run), .score(score)
	);

	digit_scan #(.DIGIT_CYCLES(DIGIT_CYCLES)) u_digits (
		.clk(clk), .rst_n(rst_n), .score(score), .sel(sel), .sco_data(sco_data)
	);

	matrix_scan #(.ROW_HOLD_CYCLES(ROW_HOLD_CYCLES)) u_matrix (
		.clk(clk), .rst_n(rst_n), .row_bits(row_bits), .row_addr(row_addr),
		.c_data(c_data), .c_clk(c_clk), .c_st(c_st), .c_addr(c_addr)
	);

	assign c_oe = ~on_off;	// driver enable is active low
	assign lled = {6'd0, state};

endmodule

//--- road_frame.sv
`timescale 1ns/1ps

module road_frame (
	input  logic                          clk,
	input  logic                          rst_n,
	input  race_pkg::game_state_t         state,
	input  race_pkg::lane_t               lane,
	input  logic                          step,
	input  logic                          start_run,
	input  logic [race_pkg::ROW_BITS-1:0] row_addr,
	output race_pkg::row_t                row_bits,
	output logic                          crash
);

	logic [race_pkg::OFFSET_BITS-1:0] offset;
	logic [race_pkg::OFFSET_BITS-1:0] win_idx;
	logic [race_pkg::OFFSET_BITS-1:0] crash_idx;
	race_pkg::row_t                   route_row;
	race_pkg::row_t                   crash_row;
	race_pkg::row_t                   under_car;
	logic [2:0]                       car_row;
	logic                             show_car;

	// table length is a power of two so the adds wrap by themselves
	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n)
			offset <= '0;
		else if (start_run)
			offset <= '0;
		else if (step)
			offset <= offset + 1'b1;
	end

	assign win_idx   = offset + race_pkg::OFFSET_BITS'(row_addr);
	assign route_row = race_pkg::ROUTE[win_idx];

	assign show_car = (state != race_pkg::ST_IDLE) && (row_addr < 4);
	assign car_row  = race_pkg::CAR_ROWS[row_addr[1:0]];

	always_comb begin
		row_bits = route_row;
		if (show_car)
			row_bits = route_row | (race_pkg::row_t'(car_row) << lane);
	end

	// road under the bottom row of the car
	assign crash_idx = offset + race_pkg::OFFSET_BITS'(race_pkg::CRASH_ROW);
	assign crash_row = race_pkg::ROUTE[crash_idx];
	assign under_car = crash_row >> lane;
	assign crash     = |under_car[2:0];

endmodule

//--- run.sh
#!/bin/sh
# build and run the race testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f race.f --top-module race_tb -o race_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/race_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -q "Testbench passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- score_counter.sv
`timescale 1ns/1ps

module score_counter (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           step,
	input  logic           start_run,
	output race_pkg::bcd_t score
);

	race_pkg::bcd_t score_inc;

	// ripple the carry through the four digits, 9999 rolls to 0000
	always_comb begin
		logic carry;
		carry     = 1'b1;
		score_inc = score;
		for (int i = 0; i < 4; i++) begin
			if (carry) begin
				if (score[i*4 +: 4] == 4'd9) begin
					score_inc[i*4 +: 4] = 4'd0;
				end else begin
					score_inc[i*4 +: 4] = score[i*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n)
			score <= '0;
		else if (start_run)
			score <= '0;
		else if (step)
			score <= score_inc;
	end

endmodule

//--- step_timer.sv
`timescale 1ns/1ps

module step_timer #(
	parameter int STEP_CYCLES = 20_000_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  race_pkg::game_state_t state,
	input  logic                  pause,
	input  logic                  start_run,
	output logic                  step
);

	localparam int CNT_BITS = $clog2(STEP_CYCLES + 1);

	logic [CNT_BITS-1:0] cnt;

	always_ff @(posedge clk or posedge rst_n) begin
		if (rst_n) begin
			cnt  <= '0;
			step <= 1'b0;
		end else begin
			step <= 1'b0;
			if (start_run) begin
				cnt <= '0;
			end else if (state == race_pkg::ST_RUN && !pause) begin
				if (cnt == CNT_BITS'(STEP_CYCLES - 1)) begin
					cnt  <= '0;
					step <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule
